//--- Bender.yml
package:
  name: ntt_core

sources:
  - include_dirs:
      - .
    files:
      - ntt_pkg.sv
      - ntt_coef_ram.sv
      - ntt_loader.sv
      - ntt_butterfly.sv
      - ntt_controller.sv
      - ntt_unloader.sv
      - ntt_core.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_ntt.sv

//--- all.f
+incdir+.
ntt_pkg.sv
ntt_coef_ram.sv
ntt_loader.sv
ntt_butterfly.sv
ntt_controller.sv
ntt_unloader.sv
ntt_core.sv
tb_ntt.sv

//--- ntt_butterfly.sv
// Cooley-Tukey butterfly, three register stages; u, v and tw must already be reduced below q
`timescale 1ns/1ps
`default_nettype none
`include "ntt_settings.svh"

module ntt_butterfly import ntt_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  coef_t q,
    input  coef_t u,
    input  coef_t v,
    input  coef_t tw,
    output coef_t sum,
    output coef_t diff
);

    logic [2*`NTT_DATA_W-1:0] prod;
    logic [`NTT_DATA_W:0]     add_full; // one carry bit
    coef_t u_d1;
    coef_t u_d2;
    coef_t t;
    coef_t sum_n;
    coef_t diff_n;

    // final add/sub with a single conditional correction
    always_comb begin
        add_full = {1'b0, u_d2} + {1'b0, t};
        sum_n    = (add_full >= {1'b0, q}) ? coef_t'(add_full - {1'b0, q}) : coef_t'(add_full);
        diff_n   = (u_d2 >= t) ? u_d2 - t : u_d2 + q - t; // wraps back into range
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            prod <= '0;
            u_d1 <= '0;
            t    <= '0;
            u_d2 <= '0;
            sum  <= '0;
            diff <= '0;
        end else begin
            // stage 1, full product
            prod <= v * tw;
            u_d1 <= u;
            // stage 2, reduce mod q
            t    <= coef_t'(prod % q);
            u_d2 <= u_d1;
            // stage 3
            sum  <= sum_n;
            diff <= diff_n;
        end
    end

endmodule

`default_nettype wire

//--- ntt_coef_ram.sv
// two-port register-array RAM, one-cycle read latency, write port 1 wins if both ports hit one address
`timescale 1ns/1ps
`default_nettype none

module ntt_coef_ram import ntt_pkg::*; #(
    parameter int DEPTH_W = 4
) (
    input  logic               clk,
    input  logic               we0,
    input  logic               we1,
    input  logic [DEPTH_W-1:0] waddr0,
    input  logic [DEPTH_W-1:0] waddr1,
    input  coef_t              wdata0,
    input  coef_t              wdata1,
    input  logic [DEPTH_W-1:0] raddr0,
    input  logic [DEPTH_W-1:0] raddr1,
    output coef_t              rdata0,
    output coef_t              rdata1
);

    coef_t mem [0:(1 << DEPTH_W) - 1];

    always_ff @(posedge clk) begin
        if (we0) begin
            mem[waddr0] <= wdata0;
        end
        if (we1) begin
            mem[waddr1] <= wdata1; // later write, takes priority
        end
    end

    // read data registered, old contents on a same-cycle write
    always_ff @(posedge clk) begin
        rdata0 <= mem[raddr0];
        rdata1 <= mem[raddr1];
    end

endmodule

`default_nettype wire

//--- ntt_controller.sv
// forward NTT sequencer, one butterfly per cycle; each stage drains fully before the next starts
`timescale 1ns/1ps
`default_nettype none
`include "ntt_settings.svh"

module ntt_controller import ntt_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     start,
    input  logic     loader_busy,
    input  logic     unload_busy,
    input  logic     ld_we,
    input  addr_t    ld_waddr,
    input  coef_t    ld_wdata,
    input  addr_t    out_raddr,
    input  coef_t    sum,
    input  coef_t    diff,
    output logic     transform_busy,
    output logic     transform_done,
    output logic     we0,
    output logic     we1,
    output addr_t    waddr0,
    output addr_t    waddr1,
    output addr_t    raddr0,
    output addr_t    raddr1,
    output coef_t    wdata0,
    output coef_t    wdata1,
    output tw_addr_t tw_raddr
);

    localparam int DLY     = `NTT_BFLY_LAT + 1;   // RAM read plus butterfly
    localparam int STAGE_W = $clog2(`NTT_LOG_N);
    localparam int DRAIN_W = $clog2(`NTT_BFLY_LAT + 2);

    ntt_state_e         state;
    logic [STAGE_W-1:0] stage;
    logic [DRAIN_W-1:0] drain_cnt;
    tw_addr_t           blk;            // block index within the stage
    tw_addr_t           j;              // pair index within the block
    addr_t              half;           // h = 2^stage
    addr_t              a_lo;
    addr_t              a_hi;
    logic               j_last;
    logic               blk_last;
    logic [DLY-1:0]     wb_vld;
    addr_t              wb_a0 [DLY];
    addr_t              wb_a1 [DLY];

    assign half     = addr_t'(1) << stage;
    assign a_lo     = (addr_t'(blk) << (stage + 1)) | addr_t'(j);
    assign a_hi     = a_lo | half;
    assign tw_raddr = j << (`NTT_LOG_N - 1 - stage); // j * N/(2h)
    assign j_last   = (addr_t'(j) == half - 1'b1);
    assign blk_last = (blk == tw_addr_t'(((`NTT_N / 2) >> stage) - 1));

    assign transform_busy = (state != st_idle) | transform_done | unload_busy;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state          <= st_idle;
            stage          <= '0;
            blk            <= '0;
            j              <= '0;
            drain_cnt      <= '0;
            transform_done <= 1'b0;
        end else begin
            transform_done <= 1'b0;
            case (state)
                st_idle: begin
                    if (start && !loader_busy && !transform_busy) begin
                        state <= st_transform;
                    end
                end
                st_transform: begin
                    j <= j_last ? tw_addr_t'(0) : j + 1'b1;
                    if (j_last) begin
                        blk <= blk_last ? tw_addr_t'(0) : blk + 1'b1;
                        if (blk_last) begin
                            state <= st_drain; // all N/2 pairs issued
                        end
                    end
                end
                st_drain: begin
                    drain_cnt <= drain_cnt + 1'b1;
                    if (drain_cnt == DRAIN_W'(`NTT_BFLY_LAT + 1)) begin
                        drain_cnt <= '0;
                        if (stage == STAGE_W'(`NTT_LOG_N - 1)) begin
                            stage          <= '0;
                            state          <= st_idle;
                            transform_done <= 1'b1;
                        end else begin
                            stage <= stage + 1'b1;
                            state <= st_transform;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // write-back line, matches read latency plus butterfly depth
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wb_vld <= '0;
        end else begin
            wb_vld <= {wb_vld[DLY-2:0], state == st_transform};
        end
    end

    always_ff @(posedge clk) begin
        wb_a0[0] <= a_lo;
        wb_a1[0] <= a_hi;
        for (int i = 1; i < DLY; i++) begin
            wb_a0[i] <= wb_a0[i - 1];
            wb_a1[i] <= wb_a1[i - 1];
        end
    end

    // loader and unloader own the ports while idle
    always_comb begin
        if (state == st_idle) begin
            we0    = ld_we;
            we1    = 1'b0;
            waddr0 = ld_waddr;
            waddr1 = ld_waddr;
            wdata0 = ld_wdata;
            wdata1 = ld_wdata;
            raddr0 = out_raddr;
            raddr1 = out_raddr;
        end else begin
            we0    = wb_vld[DLY-1];
            we1    = wb_vld[DLY-1];
            waddr0 = wb_a0[DLY-1];
            waddr1 = wb_a1[DLY-1];
            wdata0 = sum;   // u + t to a
            wdata1 = diff;  // u - t to a + h
            raddr0 = a_lo;
            raddr1 = a_hi;
        end
    end

endmodule

`default_nettype wire

//--- ntt_core.sv
// single-PE forward NTT top; load twiddles and q once, then load, start and collect N words per transform
`timescale 1ns/1ps
`default_nettype none
`include "ntt_settings.svh"

module ntt_core import ntt_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  load_w,
    input  logic  load_data,
    input  logic  start,
    input  coef_t din,
    output logic  done,
    output logic  dout_valid,
    output coef_t dout
);

    logic     loader_busy;
    logic     transform_busy;
    logic     transform_done;
    logic     unload_busy;
    logic     tw_we;
    tw_addr_t tw_waddr;
    coef_t    tw_wdata;
    tw_addr_t tw_raddr;
    coef_t    tw_rdata;
    coef_t    q;
    logic     ld_we;
    addr_t    ld_waddr;
    coef_t    ld_wdata;
    addr_t    out_raddr;
    logic     we0;
    logic     we1;
    addr_t    waddr0;
    addr_t    waddr1;
    addr_t    raddr0;
    addr_t    raddr1;
    coef_t    wdata0;
    coef_t    wdata1;
    coef_t    rdata0;
    coef_t    rdata1;
    coef_t    sum;
    coef_t    diff;

    ntt_loader loader_i (
        .clk(clk), .reset(reset), .load_w(load_w), .load_data(load_data),
        .transform_busy(transform_busy), .din(din), .loader_busy(loader_busy),
        .tw_we(tw_we), .tw_waddr(tw_waddr), .tw_wdata(tw_wdata), .q(q),
        .ld_we(ld_we), .ld_waddr(ld_waddr), .ld_wdata(ld_wdata)
    );

    ntt_controller ctrl_i (
        .clk(clk), .reset(reset), .start(start), .loader_busy(loader_busy),
        .unload_busy(unload_busy), .ld_we(ld_we), .ld_waddr(ld_waddr),
        .ld_wdata(ld_wdata), .out_raddr(out_raddr), .sum(sum), .diff(diff),
        .transform_busy(transform_busy), .transform_done(transform_done),
        .we0(we0), .we1(we1), .waddr0(waddr0), .waddr1(waddr1),
        .raddr0(raddr0), .raddr1(raddr1), .wdata0(wdata0), .wdata1(wdata1),
        .tw_raddr(tw_raddr)
    );

    ntt_coef_ram #(.DEPTH_W(`NTT_LOG_N)) coef_ram_i (
        .clk(clk), .we0(we0), .we1(we1), .waddr0(waddr0), .waddr1(waddr1),
        .wdata0(wdata0), .wdata1(wdata1), .raddr0(raddr0), .raddr1(raddr1),
        .rdata0(rdata0), .rdata1(rdata1)
    );

    // twiddles use port 0 only
    ntt_coef_ram #(.DEPTH_W(`NTT_LOG_N - 1)) tw_ram_i (
        .clk(clk), .we0(tw_we), .we1(1'b0), .waddr0(tw_waddr), .waddr1(tw_waddr),
        .wdata0(tw_wdata), .wdata1(tw_wdata), .raddr0(tw_raddr), .raddr1(tw_raddr),
        .rdata0(tw_rdata), .rdata1()
    );

    ntt_butterfly bfly_i (
        .clk(clk), .reset(reset), .q(q), .u(rdata0), .v(rdata1), .tw(tw_rdata),
        .sum(sum), .diff(diff)
    );

    ntt_unloader unloader_i (
        .clk(clk), .reset(reset), .transform_done(transform_done), .rdata0(rdata0),
        .out_raddr(out_raddr), .unload_busy(unload_busy), .done(done),
        .dout(dout), .dout_valid(dout_valid)
    );

endmodule

`default_nettype wire

//--- ntt_loader.sv
// word-serial loader: din must carry N/2 twiddles then q, or N data words, with no gaps after the pulse
`timescale 1ns/1ps
`default_nettype none
`include "ntt_settings.svh"

module ntt_loader import ntt_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     load_w,
    input  logic     load_data,
    input  logic     transform_busy,
    input  coef_t    din,
    output logic     loader_busy,
    output logic     tw_we,
    output tw_addr_t tw_waddr,
    output coef_t    tw_wdata,
    output coef_t    q,
    output logic     ld_we,
    output addr_t    ld_waddr,
    output coef_t    ld_wdata
);

    logic  mode_w;   // twiddles, then q
    logic  mode_d;   // polynomial words
    addr_t cnt;
    addr_t cnt_rev;
    logic  q_word;

    assign q_word      = mode_w && (cnt == addr_t'(`NTT_N / 2));
    assign loader_busy = mode_w | mode_d;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mode_w <= 1'b0;
            mode_d <= 1'b0;
            cnt    <= '0;
        end else if (mode_w) begin
            mode_w <= !q_word;
            cnt    <= q_word ? addr_t'(0) : cnt + 1'b1;
        end else if (mode_d) begin
            if (cnt == addr_t'(`NTT_N - 1)) begin
                mode_d <= 1'b0;
            end
            cnt <= cnt + 1'b1; // wraps back to 0 on the last word
        end else if (!transform_busy) begin
            mode_w <= load_w;
            mode_d <= load_data & ~load_w; // load_w wins if both arrive
        end
    end

    always_ff @(posedge clk) begin
        if (q_word) begin
            q <= din;
        end
    end

    // standard order in, bit-reversed order in the RAM
    always_comb begin
        for (int i = 0; i < `NTT_LOG_N; i++) begin
            cnt_rev[i] = cnt[`NTT_LOG_N - 1 - i];
        end
    end

    assign tw_we    = mode_w && (cnt < addr_t'(`NTT_N / 2));
    assign tw_waddr = cnt[`NTT_LOG_N-2:0];
    assign tw_wdata = din;
    assign ld_we    = mode_d;
    assign ld_waddr = cnt_rev;
    assign ld_wdata = din;

endmodule

`default_nettype wire

//--- ntt_pkg.sv
// shared types for the single-PE NTT; widths follow ntt_settings.svh and N must stay a power of two
`default_nettype none
`include "ntt_settings.svh"

package ntt_pkg;

    typedef logic [`NTT_DATA_W-1:0] coef_t;    // coefficient, twiddle or q
    typedef logic [`NTT_LOG_N-1:0]  addr_t;    // coefficient RAM address
    typedef logic [`NTT_LOG_N-2:0]  tw_addr_t; // twiddle RAM address, N/2 entries

    // transform sequencing
    typedef enum logic [1:0] {
        st_idle,
        st_transform,
        st_drain
    } ntt_state_e;

endpackage

`default_nettype wire

//--- ntt_settings.svh
// ring size must be a power of two; data width must hold q, and the butterfly depth is fixed at 3
`ifndef NTT_SETTINGS_SVH
`define NTT_SETTINGS_SVH

// ring size N and its log
`define NTT_N        16
`define NTT_LOG_N    4

// coefficient, twiddle and modulus width
`define NTT_DATA_W   16

// butterfly register stages, multiply, reduce and add/sub
`define NTT_BFLY_LAT 3

`endif

//--- ntt_unloader.sv
// result streamer, N words in natural order right after done; no back-pressure, consumer takes every word
`timescale 1ns/1ps
`default_nettype none
`include "ntt_settings.svh"

module ntt_unloader import ntt_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  transform_done,
    input  coef_t rdata0,
    output addr_t out_raddr,
    output logic  unload_busy,
    output logic  done,
    output coef_t dout,
    output logic  dout_valid
);

    logic  rd_active;   // read addresses being issued
    addr_t rd_cnt;

    assign out_raddr   = rd_cnt;
    assign dout        = rdata0;      // RAM output is already registered
    assign unload_busy = rd_active | dout_valid;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_active  <= 1'b0;
            rd_cnt     <= '0;
            done       <= 1'b0;
            dout_valid <= 1'b0;
        end else begin
            done       <= transform_done;
            dout_valid <= rd_active; // one cycle behind the read address
            if (transform_done) begin
                rd_active <= 1'b1;
                rd_cnt    <= '0;
            end else if (rd_active) begin
                if (rd_cnt == addr_t'(`NTT_N - 1)) begin
                    rd_active <= 1'b0;
                end
                rd_cnt <= rd_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- tb_ntt.sv
// directed testbench for ntt_core; assumes q = 257 and w = 249 with N = 16, no back-pressure on dout
`timescale 1ns/1ps
`default_nettype none
`include "ntt_settings.svh"

module tb_ntt import ntt_pkg::*; ();

    localparam int N   = `NTT_N;
    localparam int Q   = 257;
    localparam int W   = 249;   // primitive 16th root mod 257
    localparam int XFORM_CYC  = `NTT_LOG_N * (N / 2 + `NTT_BFLY_LAT + 2);
    localparam int DONE_WAIT  = 2 * XFORM_CYC + 10;
    localparam int TEST_CYC   = 4 * (N / 2 + 1 + N + XFORM_CYC + N + 10);
    localparam int CYCLE_LIMIT = 5 * TEST_CYC;

    logic  clk;
    logic  reset;
    logic  load_w;
    logic  load_data;
    logic  start;
    coef_t din;
    logic  done;
    logic  dout_valid;
    coef_t dout;

    coef_t x_vec   [N];
    coef_t exp_vec [N];
    coef_t res_vec [N];
    int    seed = 40527;
    int    err_count = 0;
    int    tests_run = 0;
    int    tests_failed = 0;
    int    cycles = 0;

    ntt_core dut_i (
        .clk(clk), .reset(reset), .load_w(load_w), .load_data(load_data),
        .start(start), .din(din), .done(done), .dout_valid(dout_valid), .dout(dout)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // run limit covering every test with margin
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: the run went past %0d clock cycles", CYCLE_LIMIT);
            $display("TESTS FAILED");
            $finish;
        end
    end

    function automatic int mod_pow(int b, int e);
        int r;
        r = 1;
        for (int i = 0; i < e; i++) begin
            r = (r * b) % Q;
        end
        return r;
    endfunction

    task automatic check_coef(string name, coef_t expected, coef_t actual);
        if (expected !== actual) begin
            $display("ERR t=%0t %s expected %0d actual %0d", $time, name, expected, actual);
            err_count++;
        end
    endtask

    task automatic check_bit(string name, logic expected, logic actual);
        if (expected !== actual) begin
            $display("ERR t=%0t %s expected %0b actual %0b", $time, name, expected, actual);
            err_count++;
        end
    endtask

    // naive transform X[k] = sum x[j] w^(jk) mod q
    task automatic compute_dft();
        int acc;
        for (int k = 0; k < N; k++) begin
            acc = 0;
            for (int j = 0; j < N; j++) begin
                acc = (acc + int'(x_vec[j]) * mod_pow(W, j * k)) % Q;
            end
            exp_vec[k] = coef_t'(acc);
        end
    endtask

    task automatic load_twiddles();
        @(posedge clk); #10;
        load_w = 1'b1;
        @(posedge clk); #10;
        load_w = 1'b0;
        for (int k = 0; k < N / 2; k++) begin
            din = coef_t'(mod_pow(W, k));
            @(posedge clk); #10;
        end
        din = coef_t'(Q);   // q follows the last twiddle
        @(posedge clk); #10;
        din = '0;
    endtask

    // start_at picks the data word that carries a start pulse or -1 for none
    task automatic load_poly(int start_at);
        @(posedge clk); #10;
        load_data = 1'b1;
        @(posedge clk); #10;
        load_data = 1'b0;
        for (int i = 0; i < N; i++) begin
            din   = x_vec[i];
            start = (i == start_at);
            @(posedge clk); #10;
        end
        start = 1'b0;
        din   = '0;
    endtask

    task automatic run_and_collect();
        int waited;
        int got;
        logic seen;
        waited = 0;
        got    = 0;
        seen   = 1'b0;
        @(posedge clk); #10;
        start = 1'b1;
        @(posedge clk); #10;
        start = 1'b0;
        while (!seen && waited < DONE_WAIT) begin
            @(negedge clk);
            waited++;
            seen = done;
        end
        if (!seen) begin
            $display("done did not arrive within %0d cycles of start", DONE_WAIT);
            err_count++;
        end else begin
            for (int i = 0; i < N + 4; i++) begin
                @(negedge clk);
                check_bit("done", 1'b0, done);   // single-cycle pulse
                check_bit("dout_valid", i < N, dout_valid);
                if (dout_valid) begin
                    if (got < N) res_vec[got] = dout;
                    got++;
                end
            end
            if (got != N) begin
                $display("output frame held %0d words instead of %0d", got, N);
                err_count++;
            end
        end
    endtask

    task automatic compare_result();
        for (int k = 0; k < N; k++) begin
            check_coef($sformatf("dout[%0d]", k), exp_vec[k], res_vec[k]);
        end
    endtask

    task automatic report_test(string name, int err_before);
        tests_run++;
        if (err_count == err_before) begin
            $display("test %0s: pass", name);
        end else begin
            tests_failed++;
            $display("test %0s: fail, %0d errors", name, err_count - err_before);
        end
    endtask

    task automatic test_impulse();
        int e0;
        e0 = err_count;
        for (int i = 0; i < N; i++) x_vec[i] = (i == 0) ? coef_t'(1) : coef_t'(0);
        for (int k = 0; k < N; k++) exp_vec[k] = coef_t'(1);
        load_twiddles();
        load_poly(-1);
        run_and_collect();
        compare_result();
        report_test("impulse", e0);
    endtask

    task automatic test_constant();
        int e0;
        e0 = err_count;
        for (int i = 0; i < N; i++) x_vec[i] = coef_t'(5);
        for (int k = 0; k < N; k++) exp_vec[k] = (k == 0) ? coef_t'((5 * N) % Q) : coef_t'(0);
        load_poly(-1);
        run_and_collect();
        compare_result();
        report_test("constant", e0);
    endtask

    task automatic test_random(string name);
        int e0;
        e0 = err_count;
        for (int i = 0; i < N; i++) x_vec[i] = coef_t'({$random(seed)} % Q);
        compute_dft();
        load_poly(-1);
        run_and_collect();
        compare_result();
        report_test(name, e0);
    endtask

    task automatic test_ignored_start();
        int e0;
        e0 = err_count;
        for (int i = 0; i < N; i++) x_vec[i] = coef_t'({$random(seed)} % Q);
        compute_dft();
        load_poly(5);   // start arrives while the loader is busy
        for (int i = 0; i < XFORM_CYC + 4; i++) begin
            @(negedge clk);
            check_bit("done", 1'b0, done);
            check_bit("dout_valid", 1'b0, dout_valid);
        end
        run_and_collect();
        compare_result();
        report_test("ignored_start", e0);
    endtask

    initial begin
        reset     = 1'b1;
        load_w    = 1'b0;
        load_data = 1'b0;
        start     = 1'b0;
        din       = '0;
        repeat (2) @(posedge clk);
        #10;
        reset = 1'b0;

        test_impulse();
        test_constant();
        test_random("random");
        test_random("back_to_back");   // twiddles and q kept from the first load
        test_ignored_start();

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_count);
        if (err_count == 0 && tests_failed == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
